//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_qtab_mmio -f vlog.f -Mdir obj_dir
	./obj_dir/Vtb_qtab_mmio > sim.log 2>&1
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/mgmt_wb_slave.sv
module mgmt_wb_slave (
    input  logic                 pcie_clk,
    input  logic                 pcie_reset_n,
    input  qtab_pkg::mgmt_addr_t wb_adr,
    input  qtab_pkg::word_t      wb_dat_w,
    input  logic                 wb_we,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    output qtab_pkg::word_t      wb_dat_r,
    output logic                 wb_ack,
    output qtab_pkg::ctrl_regs_t control_regs,
    qtab_req_if.requester        req,
    input  qtab_pkg::q_entry_t   rd_entry,
    input  logic                 rd_valid
);
    import qtab_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_grant,
        st_data
    } state_e;

    state_e     state;
    logic       access;
    logic       is_reg;
    logic       is_table;
    mgmt_addr_t offset;
    logic       req_q;
    logic       is_write_q;
    page_idx_t  page_q;
    q_field_e   field_q;
    word_t      data_q;

    // ack is still high in the cycle the master drops stb
    assign access   = wb_cyc && wb_stb && !wb_ack;
    assign is_reg   = wb_adr < mgmt_addr_t'(NB_CONTROL_REGS);
    assign is_table = !is_reg && (wb_adr < mgmt_addr_t'(MGMT_TABLE_END));
    assign offset   = wb_adr - mgmt_addr_t'(MGMT_TABLE_BASE);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state        <= st_idle;
            req_q        <= 1'b0;
            is_write_q   <= 1'b0;
            wb_ack       <= 1'b0;
            control_regs <= '0;
        end else begin
            wb_ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (access && is_table) begin
                        req_q      <= 1'b1;
                        is_write_q <= wb_we;
                        state      <= st_grant;
                    end else if (access) begin
                        if (is_reg && wb_we) begin
                            control_regs[wb_adr[CTRL_IDX_W-1:0]] <= wb_dat_w;
                        end
                        // out of range words are acked here as well
                        wb_ack <= 1'b1;
                    end
                end
                st_grant: begin
                    if (req.grant) begin
                        req_q <= 1'b0;
                        if (is_write_q) begin
                            wb_ack <= 1'b1;
                            state  <= st_idle;
                        end else begin
                            state <= st_data;
                        end
                    end
                end
                st_data: begin
                    if (rd_valid) begin
                        wb_ack <= 1'b1;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (state == st_idle && access) begin
            page_q  <= offset[FIELD_W +: PAGE_IDX_W];
            field_q <= q_field_e'(offset[FIELD_W-1:0]);
            data_q  <= wb_dat_w;
            wb_dat_r <= is_reg ? control_regs[wb_adr[CTRL_IDX_W-1:0]] : '0;
        end else if (state == st_data && rd_valid) begin
            wb_dat_r <= rd_entry[field_q];
        end
    end

    assign req.req      = req_q;
    assign req.is_write = is_write_q;
    assign req.page     = page_q;
    assign req.wr_data  = {NB_FIELDS{data_q}};

    // only the addressed field is written
    always_comb begin
        req.wr_mask = '0;
        if (is_write_q) begin
            req.wr_mask[field_q] = 1'b1;
        end
    end

endmodule

//--- rtl/mmio_req_decoder.sv
module mmio_req_decoder (
    input  logic                             pcie_clk,
    input  logic                             pcie_reset_n,
    input  logic [qtab_pkg::PCIE_ADDR_W-1:0] address,
    input  logic                             write,
    input  logic                             read,
    input  qtab_pkg::mmio_data_t             writedata,
    input  qtab_pkg::mmio_be_t               byteenable,
    qtab_req_if.requester                    req
);
    import qtab_pkg::*;

    logic        in_region;
    page_idx_t   page_in;
    field_mask_t lane_full;
    logic        wr_pend;
    page_idx_t   wr_page;
    field_mask_t wr_mask_q;
    q_entry_t    wr_data_q;
    logic        rd_pend;
    page_idx_t   rd_page;

    // upper half of the BAR is not queue space
    assign in_region = !address[REGION_BIT];
    assign page_in   = address[PAGE_LSB +: PAGE_IDX_W];

    // a lane is written only when all of its bytes are enabled
    always_comb begin
        lane_full         = '0;
        lane_full[head]   = &byteenable[int'(head) * BE_PER_WORD +: BE_PER_WORD];
        lane_full[l_addr] = &byteenable[int'(l_addr) * BE_PER_WORD +: BE_PER_WORD];
        lane_full[h_addr] = &byteenable[int'(h_addr) * BE_PER_WORD +: BE_PER_WORD];
        // tails are owned by the hardware
        lane_full[tail]   = 1'b0;
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            wr_pend <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            wr_pend <= write && in_region;
            if (req.grant && !req.is_write) begin
                rd_pend <= 1'b0;
            end
            if (read && in_region) begin
                rd_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (write) begin
            wr_page   <= page_in;
            wr_mask_q <= lane_full;
            wr_data_q <= q_entry_t'(writedata[$bits(q_entry_t)-1:0]);
        end
        if (read && in_region) begin
            rd_page <= page_in;
        end
    end

    // a write goes out in the cycle after it is taken, a pending read waits behind it
    assign req.req      = wr_pend || rd_pend;
    assign req.is_write = wr_pend;
    assign req.page     = wr_pend ? wr_page : rd_page;
    assign req.wr_mask  = wr_pend ? wr_mask_q : '0;
    assign req.wr_data  = wr_data_q;

endmodule

//--- rtl/qtab_mmio_top.sv
module qtab_mmio_top (
    input  logic                             pcie_clk,
    input  logic                             pcie_reset_n,
    input  logic [qtab_pkg::PCIE_ADDR_W-1:0] pcie_address,
    input  logic                             pcie_write,
    input  logic                             pcie_read,
    input  qtab_pkg::mmio_data_t             pcie_writedata,
    input  qtab_pkg::mmio_be_t               pcie_byteenable,
    output qtab_pkg::mmio_data_t             pcie_readdata,
    output logic                             pcie_readdatavalid,
    input  qtab_pkg::mgmt_addr_t             wb_adr,
    input  qtab_pkg::word_t                  wb_dat_w,
    output qtab_pkg::word_t                  wb_dat_r,
    input  logic                             wb_we,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    output logic                             wb_ack,
    output qtab_pkg::ctrl_regs_t             control_regs
);
    import qtab_pkg::*;

    q_entry_t mgmt_entry;
    logic     mgmt_valid;
    logic     rd_to_host;
    logic     rd_to_mgmt;
    logic     rd_from_dsc;

    qtab_req_if  host_req ();
    qtab_req_if  mgmt_req ();
    qtab_port_if pkt_port ();
    qtab_port_if dsc_port ();

    // input side
    mmio_req_decoder u_mmio_req_decoder (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .address      (pcie_address),
        .write        (pcie_write),
        .read         (pcie_read),
        .writedata    (pcie_writedata),
        .byteenable   (pcie_byteenable),
        .req          (host_req)
    );

    mgmt_wb_slave u_mgmt_wb_slave (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_we        (wb_we),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .control_regs (control_regs),
        .req          (mgmt_req),
        .rd_entry     (mgmt_entry),
        .rd_valid     (mgmt_valid)
    );

    // processing part
    qtab_port_arbiter u_qtab_port_arbiter (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .host         (host_req),
        .mgmt         (mgmt_req),
        .pkt_port     (pkt_port),
        .dsc_port     (dsc_port),
        .rd_to_host   (rd_to_host),
        .rd_to_mgmt   (rd_to_mgmt),
        .rd_from_dsc  (rd_from_dsc)
    );

    queue_table_bank u_pkt_bank (
        .pcie_clk (pcie_clk),
        .port     (pkt_port)
    );

    queue_table_bank u_dsc_bank (
        .pcie_clk (pcie_clk),
        .port     (dsc_port)
    );

    // output side
    qtab_read_return u_qtab_read_return (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .pkt_data           (pkt_port.rd_data),
        .dsc_data           (dsc_port.rd_data),
        .rd_to_host         (rd_to_host),
        .rd_to_mgmt         (rd_to_mgmt),
        .rd_from_dsc        (rd_from_dsc),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid),
        .mgmt_entry         (mgmt_entry),
        .mgmt_valid         (mgmt_valid)
    );

endmodule

//--- rtl/qtab_pkg.sv
package qtab_pkg;

    // queue groups, packet pages first and descriptor pages after them
    localparam int NB_PKT_QUEUES = 16;
    localparam int NB_DSC_QUEUES = 16;

    // host address layout, one 4 KiB page per queue
    localparam int PCIE_ADDR_W = 18;
    localparam int PAGE_IDX_W  = 5;
    localparam int PAGE_LSB    = 12;
    localparam int REGION_BIT  = PCIE_ADDR_W - 1;

    localparam int TABLE_AW    = 4;
    localparam int TABLE_DEPTH = 2 ** TABLE_AW;

    localparam int WORD_W      = 32;
    localparam int BE_PER_WORD = WORD_W / 8;
    localparam int NB_FIELDS   = 4;
    localparam int FIELD_W     = $clog2(NB_FIELDS);

    localparam int MMIO_DATA_W = 512;
    localparam int MMIO_BE_W   = MMIO_DATA_W / 8;

    // management word map: registers, then one word per table field
    localparam int NB_CONTROL_REGS = 8;
    localparam int CTRL_IDX_W      = $clog2(NB_CONTROL_REGS);
    localparam int MGMT_AW         = 8;
    localparam int MGMT_TABLE_BASE = NB_CONTROL_REGS;
    localparam int MGMT_TABLE_END  =
        MGMT_TABLE_BASE + (NB_PKT_QUEUES + NB_DSC_QUEUES) * NB_FIELDS;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [PAGE_IDX_W-1:0]  page_idx_t;
    typedef logic [TABLE_AW-1:0]    table_addr_t;
    typedef logic [NB_FIELDS-1:0]   field_mask_t;
    typedef logic [MMIO_DATA_W-1:0] mmio_data_t;
    typedef logic [MMIO_BE_W-1:0]   mmio_be_t;
    typedef logic [MGMT_AW-1:0]     mgmt_addr_t;

    // tail sits in the lowest word
    typedef word_t [NB_FIELDS-1:0] q_entry_t;

    typedef word_t [NB_CONTROL_REGS-1:0] ctrl_regs_t;

    typedef enum logic [FIELD_W-1:0] {
        tail   = 2'd0,
        head   = 2'd1,
        l_addr = 2'd2,
        h_addr = 2'd3
    } q_field_e;

endpackage

//--- rtl/qtab_port_arbiter.sv
module qtab_port_arbiter (
    input  logic          pcie_clk,
    input  logic          pcie_reset_n,
    qtab_req_if.arbiter   host,
    qtab_req_if.arbiter   mgmt,
    qtab_port_if.arbiter  pkt_port,
    qtab_port_if.arbiter  dsc_port,
    output logic          rd_to_host,
    output logic          rd_to_mgmt,
    output logic          rd_from_dsc
);
    import qtab_pkg::*;

    logic        any_req;
    logic        sel_write;
    logic        sel_dsc;
    logic        grant_rd;
    page_idx_t   sel_page;
    table_addr_t sel_addr;
    field_mask_t sel_mask;
    q_entry_t    sel_data;
    logic        rd_host_q;

    // host never waits and management takes the idle cycles
    assign host.grant = host.req;
    assign mgmt.grant = mgmt.req && !host.req;
    assign any_req    = host.req || mgmt.req;

    always_comb begin
        if (host.req) begin
            sel_write = host.is_write;
            sel_page  = host.page;
            sel_mask  = host.wr_mask;
            sel_data  = host.wr_data;
        end else begin
            sel_write = mgmt.is_write;
            sel_page  = mgmt.page;
            sel_mask  = mgmt.wr_mask;
            sel_data  = mgmt.wr_data;
        end
    end

    // descriptor pages follow the packet pages
    assign sel_dsc  = sel_page >= page_idx_t'(NB_PKT_QUEUES);
    // each group holds 16 queues so the low page bits address either bank
    assign sel_addr = table_addr_t'(sel_page);
    assign grant_rd = any_req && !sel_write;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            pkt_port.rd_en   <= 1'b0;
            dsc_port.rd_en   <= 1'b0;
            pkt_port.wr_mask <= '0;
            dsc_port.wr_mask <= '0;
            rd_host_q        <= 1'b0;
            rd_to_host       <= 1'b0;
            rd_to_mgmt       <= 1'b0;
            rd_from_dsc      <= 1'b0;
        end else begin
            pkt_port.rd_en   <= grant_rd && !sel_dsc;
            dsc_port.rd_en   <= grant_rd && sel_dsc;
            pkt_port.wr_mask <= (any_req && sel_write && !sel_dsc) ? sel_mask : '0;
            dsc_port.wr_mask <= (any_req && sel_write && sel_dsc) ? sel_mask : '0;
            rd_host_q        <= host.req;
            // second tag stage lines up with the bank output
            rd_to_host  <= (pkt_port.rd_en || dsc_port.rd_en) && rd_host_q;
            rd_to_mgmt  <= (pkt_port.rd_en || dsc_port.rd_en) && !rd_host_q;
            rd_from_dsc <= dsc_port.rd_en;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (any_req) begin
            pkt_port.addr    <= sel_addr;
            pkt_port.wr_data <= sel_data;
            dsc_port.addr    <= sel_addr;
            dsc_port.wr_data <= sel_data;
        end
    end

endmodule

//--- rtl/qtab_port_if.sv
interface qtab_port_if;
    import qtab_pkg::*;

    table_addr_t addr;
    logic        rd_en;
    field_mask_t wr_mask;
    q_entry_t    wr_data;
    // valid one cycle after rd_en
    q_entry_t    rd_data;

    modport arbiter (
        output addr,
        output rd_en,
        output wr_mask,
        output wr_data,
        input  rd_data
    );

    modport bank (
        input  addr,
        input  rd_en,
        input  wr_mask,
        input  wr_data,
        output rd_data
    );

endinterface

//--- rtl/qtab_read_return.sv
module qtab_read_return (
    input  logic                 pcie_clk,
    input  logic                 pcie_reset_n,
    input  qtab_pkg::q_entry_t   pkt_data,
    input  qtab_pkg::q_entry_t   dsc_data,
    input  logic                 rd_to_host,
    input  logic                 rd_to_mgmt,
    input  logic                 rd_from_dsc,
    output qtab_pkg::mmio_data_t pcie_readdata,
    output logic                 pcie_readdatavalid,
    output qtab_pkg::q_entry_t   mgmt_entry,
    output logic                 mgmt_valid
);
    import qtab_pkg::*;

    q_entry_t entry;

    // the tag says which bank answered this cycle
    assign entry = rd_from_dsc ? dsc_data : pkt_data;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            pcie_readdatavalid <= 1'b0;
        end else begin
            pcie_readdatavalid <= rd_to_host;
        end
    end

    // entry fills the low 128 bits, the rest of the line reads zero
    always_ff @(posedge pcie_clk) begin
        if (rd_to_host) begin
            pcie_readdata <= mmio_data_t'(entry);
        end
    end

    // the slave registers its own ack and field
    assign mgmt_entry = entry;
    assign mgmt_valid = rd_to_mgmt;

endmodule

//--- rtl/qtab_req_if.sv
interface qtab_req_if;
    import qtab_pkg::*;

    logic        req;
    logic        is_write;
    page_idx_t   page;
    field_mask_t wr_mask;
    q_entry_t    wr_data;
    // one-cycle pulse, combinational from the arbiter
    logic        grant;

    modport requester (
        output req,
        output is_write,
        output page,
        output wr_mask,
        output wr_data,
        input  grant
    );

    modport arbiter (
        input  req,
        input  is_write,
        input  page,
        input  wr_mask,
        input  wr_data,
        output grant
    );

endinterface

//--- rtl/queue_table_bank.sv
module queue_table_bank (
    input logic       pcie_clk,
    qtab_port_if.bank port
);
    import qtab_pkg::*;

    // one RAM per field, so a write can touch any subset of the entry
    for (genvar f = 0; f < NB_FIELDS; f++) begin : g_field
        word_t ram [TABLE_DEPTH];
        word_t rd_q;

        always_ff @(posedge pcie_clk) begin
            if (port.wr_mask[f]) begin
                ram[port.addr] <= port.wr_data[f];
            end
        end

        // arbiter never reads and writes a bank in the same cycle
        always_ff @(posedge pcie_clk) begin
            if (port.rd_en) begin
                rd_q <= ram[port.addr];
            end
        end

        assign port.rd_data[f] = rd_q;
    end

endmodule

//--- test/tb_qtab_model.svh
`ifndef TB_QTAB_MODEL_SVH
`define TB_QTAB_MODEL_SVH

// expected contents of both banks, indexed by host page 0 to 31
q_entry_t   model_tab [NB_PKT_QUEUES + NB_DSC_QUEUES];
ctrl_regs_t model_regs;

// management word of one table field, fields follow the eight registers
function automatic int field_word(int page, int field);
    return 8 + page * 4 + field;
endfunction

// known fill value, different for every field word
function automatic word_t fill_value(int page, int field);
    word_t w;
    w = word_t'(field_word(page, field));
    return 32'h5a000000 | (w << 16) | (~w & 32'h000000ff);
endfunction

// head, l_addr and h_addr take a lane only with all four byte enables set
function automatic void host_write_model(int page, mmio_data_t data, mmio_be_t be);
    for (int f = 1; f < 4; f++) begin
        if (be[f * 4 +: 4] == 4'hf) begin
            model_tab[page][f] = data[f * 32 +: 32];
        end
    end
endfunction

// a host read returns the entry in the low 128 bits, upper bits zero
function automatic mmio_data_t host_read_model(int page);
    mmio_data_t line;
    line = '0;
    line[127:0] = model_tab[page];
    return line;
endfunction

`endif

//--- test/tb_qtab_mmio.sv
module tb_qtab_mmio;
    timeunit 1ns;
    timeprecision 1ps;
    import qtab_pkg::*;

    localparam int unsigned SEED = 32'h143b14c4;

    logic                   pcie_clk;
    logic                   pcie_reset_n;
    logic [PCIE_ADDR_W-1:0] pcie_address;
    logic                   pcie_write;
    logic                   pcie_read;
    mmio_data_t             pcie_writedata;
    mmio_be_t               pcie_byteenable;
    mmio_data_t             pcie_readdata;
    logic                   pcie_readdatavalid;
    mgmt_addr_t             wb_adr;
    word_t                  wb_dat_w;
    word_t                  wb_dat_r;
    logic                   wb_we;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_ack;
    ctrl_regs_t             control_regs;

    int unsigned cycle;
    int          check_cnt;
    int          err_cnt;
    int          timeout_cnt;
    mmio_data_t  exp_line_q[$];
    int unsigned issue_cycle_q[$];

    `include "tb_qtab_model.svh"

    qtab_mmio_top u_qtab_mmio_top (.*);

    always #4 pcie_clk = ~pcie_clk;

    always @(posedge pcie_clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_word(string name, word_t exp, word_t got);
        check_cnt++;
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_line(mmio_data_t exp, int unsigned issued);
        check_cnt++;
        if (pcie_readdata !== exp) begin
            $display("** Error at %0t: pcie_readdata expected %h got %h",
                     $time, exp, pcie_readdata);
            err_cnt++;
        end
        // the read is taken on the edge after it was driven
        if (cycle - issued - 1 < 3) begin
            $display("host read returned after %0d cycles, fewer than 3", cycle - issued - 1);
            err_cnt++;
        end
    endtask

    // each readdatavalid answers the oldest host read in flight
    always @(negedge pcie_clk) begin
        if (pcie_reset_n && pcie_readdatavalid) begin
            if (exp_line_q.size() == 0) begin
                $display("readdatavalid at %0t with no host read pending", $time);
                err_cnt++;
            end else begin
                check_line(exp_line_q.pop_front(), issue_cycle_q.pop_front());
            end
        end
    end

    task automatic next_edge();
        @(posedge pcie_clk);
        #1;
    endtask

    task automatic host_idle();
        next_edge();
        pcie_write = 1'b0;
        pcie_read  = 1'b0;
    endtask

    task automatic host_write(int page, logic outside);
        mmio_data_t data;
        mmio_be_t   be;
        for (int i = 0; i < 16; i++) begin
            data[i * 32 +: 32] = $urandom;
        end
        be = {$urandom, $urandom};
        // force about half of the writable lanes fully enabled
        for (int f = 1; f < 4; f++) begin
            if ($urandom_range(1, 0) == 1) begin
                be[f * 4 +: 4] = 4'hf;
            end
        end
        next_edge();
        pcie_address    = {outside, 5'(page), 12'h000};
        pcie_writedata  = data;
        pcie_byteenable = be;
        pcie_write      = 1'b1;
        pcie_read       = 1'b0;
        if (!outside) begin
            host_write_model(page, data, be);
        end
    endtask

    task automatic host_read(int page, logic outside);
        next_edge();
        pcie_address = {outside, 5'(page), 12'h000};
        pcie_write   = 1'b0;
        pcie_read    = 1'b1;
        if (!outside) begin
            exp_line_q.push_back(host_read_model(page));
            issue_cycle_q.push_back(cycle);
        end
    endtask

    task automatic wait_reads();
        int n;
        n = 0;
        while (exp_line_q.size() != 0 && n < 50) begin
            @(posedge pcie_clk);
            n++;
        end
        if (exp_line_q.size() != 0) begin
            $display("host read got no readdatavalid within 50 cycles");
            timeout_cnt++;
            exp_line_q.delete();
            issue_cycle_q.delete();
        end
    endtask

    task automatic wb_access(int adr, logic we, word_t dat, output word_t rdata);
        int n;
        next_edge();
        wb_adr   = mgmt_addr_t'(adr);
        wb_we    = we;
        wb_dat_w = dat;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        n = 0;
        @(negedge pcie_clk);
        while (!wb_ack && n < 200) begin
            @(negedge pcie_clk);
            n++;
        end
        if (!wb_ack) begin
            $display("no wb_ack within 200 cycles for word %0d", adr);
            timeout_cnt++;
        end
        rdata = wb_dat_r;
        next_edge();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // back to back host traffic with a read only when none is in flight
    task automatic host_burst(int len);
        for (int i = 0; i < len; i++) begin
            if (exp_line_q.size() == 0 && $urandom_range(3, 0) == 0) begin
                host_read($urandom_range(31, 0), 1'b0);
            end else begin
                host_write($urandom_range(31, 0), 1'b0);
            end
        end
        host_idle();
    endtask

    task automatic check_regs();
        for (int i = 0; i < NB_CONTROL_REGS; i++) begin
            check_word($sformatf("control_regs[%0d]", i), model_regs[i], control_regs[i]);
        end
    endtask

    initial begin
        word_t rd;
        word_t val;
        int    page;
        int    field;
        int    adr;
        logic  we;
        void'($urandom(SEED));
        pcie_clk        = 1'b0;
        pcie_reset_n    = 1'b0;
        pcie_address    = '0;
        pcie_write      = 1'b0;
        pcie_read       = 1'b0;
        pcie_writedata  = '0;
        pcie_byteenable = '0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        wb_we           = 1'b0;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        check_cnt       = 0;
        err_cnt         = 0;
        timeout_cnt     = 0;
        model_regs      = '0;
        repeat (10) @(posedge pcie_clk);
        #1;
        pcie_reset_n = 1'b1;

        // known contents in both banks before any check
        for (int p = 0; p < 32; p++) begin
            for (int f = 0; f < 4; f++) begin
                wb_access(field_word(p, f), 1'b1, fill_value(p, f), rd);
                model_tab[p][f] = fill_value(p, f);
            end
        end

        // control registers and then the unmapped words
        check_regs();
        repeat (24) begin
            adr = $urandom_range(7, 0);
            val = $urandom;
            wb_access(adr, 1'b1, val, rd);
            model_regs[adr] = val;
            adr = $urandom_range(7, 0);
            wb_access(adr, 1'b0, '0, rd);
            check_word("wb_dat_r", model_regs[adr], rd);
            check_regs();
        end
        repeat (8) begin
            adr = $urandom_range(255, 136);
            wb_access(adr, 1'b1, $urandom, rd);
            wb_access(adr, 1'b0, '0, rd);
            check_word("wb_dat_r", '0, rd);
            check_regs();
        end

        // single table fields through the management port
        repeat (40) begin
            page = $urandom_range(31, 0);
            field = $urandom_range(3, 0);
            val = $urandom;
            wb_access(field_word(page, field), 1'b1, val, rd);
            model_tab[page][field] = val;
            page = $urandom_range(31, 0);
            field = $urandom_range(3, 0);
            wb_access(field_word(page, field), 1'b0, '0, rd);
            check_word("wb_dat_r", model_tab[page][field], rd);
        end

        // host lanes with the tail left as filled
        repeat (40) begin
            page = $urandom_range(31, 0);
            host_write(page, 1'b0);
            host_read(($urandom_range(1, 0) == 1) ? page : $urandom_range(31, 0), 1'b0);
            host_idle();
            wait_reads();
        end

        // upper half of the address space is ignored
        repeat (8) begin
            page = $urandom_range(31, 0);
            host_write(page, 1'b1);
            host_read(page, 1'b1);
            host_idle();
            repeat (20) @(posedge pcie_clk);
            host_read(page, 1'b0);
            host_idle();
            wait_reads();
        end

        // management access held off by a host burst
        repeat (8) begin
            page = $urandom_range(31, 0);
            field = $urandom_range(3, 0);
            we = 1'($urandom_range(1, 0));
            val = $urandom;
            fork
                wb_access(field_word(page, field), we, val, rd);
                host_burst($urandom_range(24, 8));
            join
            wait_reads();
            if (we) begin
                model_tab[page][field] = val;
                wb_access(field_word(page, field), 1'b0, '0, rd);
            end
            check_word("wb_dat_r", model_tab[page][field], rd);
        end

        $display("checks: %0d  errors: %0d  timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+test
rtl/qtab_pkg.sv
rtl/qtab_req_if.sv
rtl/qtab_port_if.sv
rtl/mmio_req_decoder.sv
rtl/mgmt_wb_slave.sv
rtl/qtab_port_arbiter.sv
rtl/queue_table_bank.sv
rtl/qtab_read_return.sv
rtl/qtab_mmio_top.sv
test/tb_qtab_mmio.sv
